/* build.f */
src/sobel_pkg.sv
src/frame_control.sv
src/line_delay.sv
src/sobel_gradient.sv
src/edge_output.sv
src/sobel_edge_top.sv
testbench/sobel_edge_properties.sv
testbench/tb_sobel_edge.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
TOP       = tb_sobel_edge
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_sobel_edge.sv */
// --------------------------------------------------
// Testbench for the Sobel edge detector
// Frame table, reference model, stimulus and monitor
// Back-pressure generator and result checks
// --------------------------------------------------

`timescale 1ns/1ps

module tb_sobel_edge;

	import sobel_pkg::*;

	localparam int SIZE_TIMEOUT = 5000;
	localparam int PEL_TIMEOUT  = 2000;
	localparam int IDLE_CYCLES  = 20;
	// Longer than the three pipeline registers
	localparam int QUIET_CYCLES = 4;

	typedef enum int {PAT_FLAT, PAT_VSTEP, PAT_HSTEP, PAT_RAMP, PAT_RANDOM} pattern_e;

	typedef struct {
		string    name;
		int       side;
		pattern_e pattern;
		bit       back_pressure;
	} frame_t;

	logic  clock;
	logic  reset;
	size_t in_size;
	logic  in_size_wr;
	logic  in_size_full;
	pel_t  in_pel;
	logic  in_pel_wr;
	logic  in_pel_full;
	pel_t  out_pel;
	logic  out_pel_wr;
	logic  out_pel_full;

	frame_t frames[$];
	int     image [MAX_WIDTH][MAX_WIDTH];
	pel_t   feed_q[$];
	pel_t   expect_q[$];
	pel_t   got_q[$];
	int     seed;
	int     bp_rnd;
	bit     bp_enable;
	bit     aborted;
	int     mismatch_count;
	int     timeout_count;
	int     other_count;

	sobel_edge_top uut (
		.clock        (clock),
		.reset        (reset),
		.in_size      (in_size),
		.in_size_wr   (in_size_wr),
		.in_size_full (in_size_full),
		.in_pel       (in_pel),
		.in_pel_wr    (in_pel_wr),
		.in_pel_full  (in_pel_full),
		.out_pel      (out_pel),
		.out_pel_wr   (out_pel_wr),
		.out_pel_full (out_pel_full)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// --------------------------------------------------
	// Back-pressure and output monitor
	// --------------------------------------------------
	initial begin
		out_pel_full = 1'b0;
		forever begin
			@(posedge clock);
			if (reset || !bp_enable) begin
				out_pel_full <= 1'b0;
			end else begin
				bp_rnd = $random(seed);
				out_pel_full <= bp_rnd[0];
			end
		end
	end

	always @(posedge clock) begin
		if (!reset && out_pel_wr && !out_pel_full) begin
			got_q.push_back(out_pel);
		end
	end

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_pel(input string name, input pel_t expected, input pel_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_size(input string name, input size_t expected, input size_t actual);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch %s rows: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeout_count++;
		aborted = 1'b1;
		$display("Timeout: %s at %0t ns", what, $time);
	endtask

	task automatic add_frame(input string name, input int side, input pattern_e pattern,
		input bit back_pressure);
		frame_t f;
		f.name          = name;
		f.side          = side;
		f.pattern       = pattern;
		f.back_pressure = back_pressure;
		frames.push_back(f);
	endtask

	// --------------------------------------------------
	// Image source and reference model
	// --------------------------------------------------
	task automatic build_image(input frame_t f);
		int v;
		feed_q.delete();
		for (int y = 0; y < f.side; y++) begin
			for (int x = 0; x < f.side; x++) begin
				case (f.pattern)
					PAT_FLAT:  v = 100;
					PAT_VSTEP: v = (x < f.side / 2) ? 0 : 255;
					PAT_HSTEP: v = (y < f.side / 2) ? 0 : 255;
					// Saturating diagonal ramp
					PAT_RAMP:  v = ((x + y) * 30 > 255) ? 255 : (x + y) * 30;
					default:   v = $random(seed) & 255;
				endcase
				image[y][x] = v;
				feed_q.push_back(pel_t'(v));
			end
		end
	endtask

	// Inner windows only, raster order of the window centres
	task automatic model_frame(input frame_t f);
		int gx;
		int gy;
		int sum;
		for (int y = 1; y < f.side - 1; y++) begin
			for (int x = 1; x < f.side - 1; x++) begin
				gx = (image[y-1][x+1] + 2 * image[y][x+1] + image[y+1][x+1])
					- (image[y-1][x-1] + 2 * image[y][x-1] + image[y+1][x-1]);
				gy = (image[y+1][x-1] + 2 * image[y+1][x] + image[y+1][x+1])
					- (image[y-1][x-1] + 2 * image[y-1][x] + image[y-1][x+1]);
				sum = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
				expect_q.push_back((sum > EDGE_THRESHOLD) ? EDGE_ON : EDGE_OFF);
			end
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic wait_frame_closed(input frame_t f);
		int waited;
		waited = 0;
		@(posedge clock);
		while (in_size_full && waited < SIZE_TIMEOUT) begin
			@(posedge clock);
			waited++;
		end
		if (in_size_full) begin
			report_timeout({"in_size_full stayed high around frame ", f.name});
		end
	endtask

	task automatic write_size(input frame_t f);
		wait_frame_closed(f);
		if (!aborted) begin
			in_size    <= size_t'(f.side);
			in_size_wr <= 1'b1;
			@(posedge clock);
			in_size_wr <= 1'b0;
		end
	endtask

	task automatic feed_pixels(input frame_t f);
		int idx;
		int waited;
		idx       = 0;
		waited    = 0;
		in_pel    <= feed_q[0];
		in_pel_wr <= 1'b1;
		while (idx < feed_q.size() && waited < PEL_TIMEOUT) begin
			@(posedge clock);
			if (in_pel_wr && !in_pel_full) begin
				idx++;
				waited = 0;
			end else begin
				waited++;
			end
			if (idx < feed_q.size()) begin
				in_pel <= feed_q[idx];
			end else begin
				in_pel_wr <= 1'b0;
			end
		end
		if (idx < feed_q.size()) begin
			in_pel_wr <= 1'b0;
			report_timeout({"pixel input never accepted in frame ", f.name});
		end
	endtask

	// No pixel is left in flight once the output stays idle
	task automatic wait_drained(input frame_t f);
		int quiet;
		int waited;
		quiet  = 0;
		waited = 0;
		while (quiet < QUIET_CYCLES && waited < PEL_TIMEOUT) begin
			@(posedge clock);
			if (out_pel_wr) begin
				quiet = 0;
			end else begin
				quiet++;
			end
			waited++;
		end
		if (quiet < QUIET_CYCLES) begin
			report_timeout({"output never went idle after frame ", f.name});
		end
	endtask

	// --------------------------------------------------
	// Result checks
	// --------------------------------------------------
	task automatic check_frame(input frame_t f);
		int   count;
		int   inner;
		pel_t actual;
		count = 0;
		inner = f.side - 2;
		while (got_q.size() != 0) begin
			actual = got_q.pop_front();
			if (expect_q.size() != 0) begin
				check_pel($sformatf("%s pixel %0d", f.name, count),
					expect_q.pop_front(), actual);
			end
			count++;
		end
		check_size(f.name, size_t'(inner), size_t'(count / inner));
		if (count % inner != 0) begin
			other_count++;
			$display("Frame %s ended with a partial output row of %0d pixels",
				f.name, count % inner);
		end
		expect_q.delete();
	endtask

	task automatic run_frames();
		foreach (frames[i]) begin
			if (!aborted) begin
				// Images are drawn away from the clock edge
				@(negedge clock);
				build_image(frames[i]);
				model_frame(frames[i]);
				bp_enable = frames[i].back_pressure;
				write_size(frames[i]);
			end
			if (!aborted) begin
				feed_pixels(frames[i]);
			end
			if (!aborted) begin
				wait_frame_closed(frames[i]);
			end
			if (!aborted) begin
				wait_drained(frames[i]);
			end
			if (!aborted) begin
				check_frame(frames[i]);
			end
		end
	endtask

	initial begin
		seed           = 48547;
		mismatch_count = 0;
		timeout_count  = 0;
		other_count    = 0;
		aborted        = 1'b0;
		bp_enable      = 1'b0;
		reset          = 1'b1;
		in_size        = '0;
		in_size_wr     = 1'b0;
		in_pel         = '0;
		in_pel_wr      = 1'b0;

		add_frame("flat_8", 8, PAT_FLAT, 1'b0);
		add_frame("vstep_8", 8, PAT_VSTEP, 1'b0);
		add_frame("hstep_8", 8, PAT_HSTEP, 1'b0);
		add_frame("random_3", 3, PAT_RANDOM, 1'b0);
		add_frame("random_5", 5, PAT_RANDOM, 1'b0);
		add_frame("random_17", 17, PAT_RANDOM, 1'b0);
		add_frame("ramp_12_bp", 12, PAT_RAMP, 1'b1);
		add_frame("random_63", 63, PAT_RANDOM, 1'b0);
		add_frame("vstep_10_bp", 10, PAT_VSTEP, 1'b1);

		repeat (5) @(posedge clock);
		reset <= 1'b0;

		run_frames();

		// Anything arriving now is a duplicate
		repeat (IDLE_CYCLES) @(posedge clock);
		if (got_q.size() != 0) begin
			other_count++;
			$display("Output produced %0d more pixels than the frames contain", got_q.size());
		end

		$display("Errors: %0d mismatches, %0d timeouts, %0d other",
			mismatch_count, timeout_count, other_count);
		if (mismatch_count + timeout_count + other_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* testbench/sobel_edge_properties.sv */
// --------------------------------------------------
// Output handshake assertions for the edge detector
// Bound to the top level
// --------------------------------------------------

`timescale 1ns/1ps

module sobel_edge_properties (
	input logic            clock,
	input logic            reset,
	input sobel_pkg::pel_t out_pel,
	input logic            out_pel_wr,
	input logic            out_pel_full
);

	import sobel_pkg::*;

	// Stalled output keeps its value and its valid
	property stall_holds_p;
		@(posedge clock) disable iff (reset)
			(out_pel_wr && out_pel_full) |=> (out_pel_wr && $stable(out_pel));
	endproperty

	property reset_clears_valid_p;
		@(posedge clock) reset |=> !out_pel_wr;
	endproperty

	// Thresholded output is binary
	property binary_output_p;
		@(posedge clock) disable iff (reset)
			out_pel_wr |-> (out_pel == EDGE_ON || out_pel == EDGE_OFF);
	endproperty

	assert property (stall_holds_p)
		else $error("out_pel or out_pel_wr changed while the output was stalled");
	assert property (reset_clears_valid_p)
		else $error("out_pel_wr high during reset");
	assert property (binary_output_p)
		else $error("out_pel is neither the edge nor the background value");

endmodule

bind sobel_edge_top sobel_edge_properties u_properties (
	.clock        (clock),
	.reset        (reset),
	.out_pel      (out_pel),
	.out_pel_wr   (out_pel_wr),
	.out_pel_full (out_pel_full)
);

/* src/sobel_edge_top.sv */
// --------------------------------------------------
// Sobel edge detector top level
// Frame control, line delay chain, gradient and output
// --------------------------------------------------

`timescale 1ns/1ps

module sobel_edge_top (
	input  logic             clock,
	input  logic             reset,
	input  sobel_pkg::size_t in_size,
	input  logic             in_size_wr,
	output logic             in_size_full,
	input  sobel_pkg::pel_t  in_pel,
	input  logic             in_pel_wr,
	output logic             in_pel_full,
	output sobel_pkg::pel_t  out_pel,
	output logic             out_pel_wr,
	input  logic             out_pel_full
);

	import sobel_pkg::*;

	stage_ctrl_t ctrl;
	size_t       width;
	logic        hold;
	// Index 0 is the current row, higher indices are older lines
	pel_t        row_pel [LINE_DELAYS+1];
	column_t     column;
	grad_pair_t  grad;
	logic        grad_valid;

	frame_control u_frame_control (
		.clock        (clock),
		.reset        (reset),
		.in_size      (in_size),
		.in_size_wr   (in_size_wr),
		.in_size_full (in_size_full),
		.in_pel       (in_pel),
		.in_pel_wr    (in_pel_wr),
		.in_pel_full  (in_pel_full),
		.hold         (hold),
		.ctrl         (ctrl),
		.pel          (row_pel[0]),
		.width        (width)
	);

	// --------------------------------------------------
	// Line delay chain
	// --------------------------------------------------
	for (genvar i = 0; i < LINE_DELAYS; i++) begin : g_delay
		line_delay u_line_delay (
			.clock   (clock),
			.reset   (reset),
			.ctrl    (ctrl),
			.width   (width),
			.pel_in  (row_pel[i]),
			.pel_out (row_pel[i+1])
		);
	end

	assign column.bottom = row_pel[0];
	assign column.middle = row_pel[1];
	assign column.top    = row_pel[LINE_DELAYS];

	sobel_gradient u_sobel_gradient (
		.clock      (clock),
		.reset      (reset),
		.ctrl       (ctrl),
		.hold       (hold),
		.column     (column),
		.grad       (grad),
		.grad_valid (grad_valid)
	);

	edge_output u_edge_output (
		.clock        (clock),
		.reset        (reset),
		.grad         (grad),
		.grad_valid   (grad_valid),
		.out_pel      (out_pel),
		.out_pel_wr   (out_pel_wr),
		.out_pel_full (out_pel_full),
		.hold         (hold)
	);

endmodule

/* src/edge_output.sv */
// --------------------------------------------------
// Absolute gradient sum and threshold
// Border drop and output register with back-pressure
// --------------------------------------------------

`timescale 1ns/1ps

module edge_output (
	input  logic                  clock,
	input  logic                  reset,
	input  sobel_pkg::grad_pair_t grad,
	input  logic                  grad_valid,
	output sobel_pkg::pel_t       out_pel,
	output logic                  out_pel_wr,
	input  logic                  out_pel_full,
	output logic                  hold
);

	import sobel_pkg::*;

	logic [GRAD_WIDTH-1:0] mag_x;
	logic [GRAD_WIDTH-1:0] mag_y;
	logic [GRAD_WIDTH-1:0] mag_sum;
	pel_t                  edge_pel;
	logic                  keep;

	function automatic logic [GRAD_WIDTH-1:0] magnitude(grad_t g);
		return g[GRAD_WIDTH-1] ? -g : g;
	endfunction

	// --------------------------------------------------
	// Threshold
	// --------------------------------------------------
	// At most 2040 so the sum fits in GRAD_WIDTH
	assign mag_x    = magnitude(grad.gx);
	assign mag_y    = magnitude(grad.gy);
	assign mag_sum  = mag_x + mag_y;
	assign edge_pel = (mag_sum > EDGE_THRESHOLD) ? EDGE_ON : EDGE_OFF;

	// Border windows never reach the output
	assign keep = grad_valid && grad.inner;

	// Whole pipeline freezes while the output waits
	assign hold = out_pel_wr && out_pel_full;

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (!hold && keep) begin
			out_pel <= edge_pel;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out_pel_wr <= 1'b0;
		end else if (!hold) begin
			out_pel_wr <= keep;
		end
	end

endmodule

/* src/sobel_gradient.sv */
// --------------------------------------------------
// 3x3 window shift register
// Horizontal and vertical Sobel gradients, registered
// --------------------------------------------------

`timescale 1ns/1ps

module sobel_gradient (
	input  logic                   clock,
	input  logic                   reset,
	input  sobel_pkg::stage_ctrl_t ctrl,
	input  logic                   hold,
	input  sobel_pkg::column_t     column,
	output sobel_pkg::grad_pair_t  grad,
	output logic                   grad_valid
);

	import sobel_pkg::*;

	column_t col_left;
	column_t col_mid;
	column_t col_right;
	logic    win_valid;
	logic    win_inner;
	grad_t   gx;
	grad_t   gy;

	// Weighted 1,2,1 sum of three pixels
	function automatic grad_t weigh(pel_t a, pel_t b, pel_t c);
		grad_t sum;
		sum = grad_t'(a) + (grad_t'(b) <<< 1) + grad_t'(c);
		return sum;
	endfunction

	// --------------------------------------------------
	// Window
	// --------------------------------------------------
	// Newest column enters on the right
	always_ff @(posedge clock) begin
		if (ctrl.step) begin
			col_left  <= col_mid;
			col_mid   <= col_right;
			col_right <= column;
			win_inner <= ctrl.inner;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else if (!hold) begin
			win_valid <= ctrl.step;
		end
	end

	// --------------------------------------------------
	// Gradients
	// --------------------------------------------------
	always_comb begin
		// Right column minus left column
		gx = weigh(col_right.top, col_right.middle, col_right.bottom)
			- weigh(col_left.top, col_left.middle, col_left.bottom);
		// Bottom row minus top row
		gy = weigh(col_left.bottom, col_mid.bottom, col_right.bottom)
			- weigh(col_left.top, col_mid.top, col_right.top);
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			grad.gx    <= gx;
			grad.gy    <= gy;
			grad.inner <= win_inner;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grad_valid <= 1'b0;
		end else if (!hold) begin
			grad_valid <= win_valid;
		end
	end

endmodule

/* src/line_delay.sv */
// --------------------------------------------------
// One image line of pixel delay
// Circular buffer that wraps at the frame width
// --------------------------------------------------

`timescale 1ns/1ps

module line_delay (
	input  logic                   clock,
	input  logic                   reset,
	input  sobel_pkg::stage_ctrl_t ctrl,
	input  sobel_pkg::size_t       width,
	input  sobel_pkg::pel_t        pel_in,
	output sobel_pkg::pel_t        pel_out
);

	import sobel_pkg::*;

	pel_t  line_mem [MAX_WIDTH];
	size_t ptr;

	// Same slot is read and then overwritten on a step
	assign pel_out = line_mem[ptr];

	always_ff @(posedge clock) begin
		if (ctrl.step) begin
			line_mem[ptr] <= pel_in;
		end
	end

	// --------------------------------------------------
	// Pointer
	// --------------------------------------------------
	// N*N steps per frame bring the pointer back to zero
	always_ff @(posedge clock) begin
		if (reset) begin
			ptr <= '0;
		end else if (ctrl.step) begin
			if (ptr == width - size_t'(1)) begin
				ptr <= '0;
			end else begin
				ptr <= ptr + size_t'(1);
			end
		end
	end

endmodule

/* src/frame_control.sv */
// --------------------------------------------------
// Frame controller for the Sobel pipeline
// Size and pixel handshakes, row and column tracking
// Pipeline step and inner window flag
// --------------------------------------------------

`timescale 1ns/1ps

module frame_control (
	input  logic                  clock,
	input  logic                  reset,
	input  sobel_pkg::size_t      in_size,
	input  logic                  in_size_wr,
	output logic                  in_size_full,
	input  sobel_pkg::pel_t       in_pel,
	input  logic                  in_pel_wr,
	output logic                  in_pel_full,
	input  logic                  hold,
	output sobel_pkg::stage_ctrl_t ctrl,
	output sobel_pkg::pel_t       pel,
	output sobel_pkg::size_t      width
);

	import sobel_pkg::*;

	logic  frame_open;
	size_t row;
	size_t col;
	logic  size_accept;
	logic  pel_accept;
	logic  last_col;
	logic  last_row;

	// --------------------------------------------------
	// Handshakes
	// --------------------------------------------------
	// A new size waits until the open frame has all its pixels
	assign in_size_full = frame_open;
	assign size_accept  = in_size_wr && !frame_open;

	// No pixels between frames or while the output is stalled
	assign in_pel_full = !frame_open || hold;
	assign pel_accept  = in_pel_wr && !in_pel_full;

	assign last_col = (col == width - size_t'(1));
	assign last_row = (row == width - size_t'(1));

	// --------------------------------------------------
	// Frame side register
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (size_accept) begin
			width <= in_size;
		end
	end

	// --------------------------------------------------
	// Raster position and frame state
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			frame_open <= 1'b0;
			row        <= '0;
			col        <= '0;
		end else if (size_accept) begin
			frame_open <= 1'b1;
			row        <= '0;
			col        <= '0;
		end else if (pel_accept) begin
			if (last_col) begin
				col <= '0;
				if (last_row) begin
					// Last pixel of the frame
					row        <= '0;
					frame_open <= 1'b0;
				end else begin
					row <= row + size_t'(1);
				end
			end else begin
				col <= col + size_t'(1);
			end
		end
	end

	// --------------------------------------------------
	// Pipeline control
	// --------------------------------------------------
	// Window is complete from the third row and third column on
	assign ctrl.step  = pel_accept;
	assign ctrl.inner = pel_accept && (row >= size_t'(2)) && (col >= size_t'(2));

	// bottom window row and first line delay see the pixel directly
	assign pel = in_pel;

endmodule

/* src/sobel_pkg.sv */
// --------------------------------------------------
// Shared widths, limits and threshold constants
// Pixel, size and gradient types
// Window column, gradient pair and stage control structs
// --------------------------------------------------

package sobel_pkg;

	// --------------------------------------------------
	// Widths and limits
	// --------------------------------------------------
	localparam int PEL_WIDTH   = 8;
	localparam int SIZE_WIDTH  = 6;
	localparam int GRAD_WIDTH  = 14;
	localparam int MAX_WIDTH   = 64;
	localparam int LINE_DELAYS = 2;

	// Sums above this value are edges
	localparam int EDGE_THRESHOLD = 200;

	// --------------------------------------------------
	// Types
	// --------------------------------------------------
	typedef logic [PEL_WIDTH-1:0] pel_t;
	typedef logic [SIZE_WIDTH-1:0] size_t;
	typedef logic signed [GRAD_WIDTH-1:0] grad_t;

	localparam pel_t EDGE_ON  = 8'd255;
	localparam pel_t EDGE_OFF = 8'd0;

	// One window column, top row first
	typedef struct packed {
		pel_t top;
		pel_t middle;
		pel_t bottom;
	} column_t;

	typedef struct packed {
		grad_t gx;
		grad_t gy;
		logic  inner;
	} grad_pair_t;

	// Step is the pipeline advance, inner marks a full window
	typedef struct packed {
		logic step;
		logic inner;
	} stage_ctrl_t;

endpackage
